// File: logic/frontend_pkg.sv
package frontend_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int xlen = 32;

    // BTB tag is the whole word address
    localparam int btb_tag_w = xlen - 2;

    ////////////////////
    // Branch opcodes
    ////////////////////

    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_b   = 6'h02;

    ////////////////////
    // Instruction word
    ////////////////////

    // Conditional branch format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
    } cond_fmt_t;

    // Unconditional jump format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] offset;
    } jump_fmt_t;

    typedef union packed {
        cond_fmt_t cond_view;
        jump_fmt_t jump_view;
    } inst_word_u;

    // One BTB line
    typedef struct packed {
        logic                 valid;
        logic [btb_tag_w-1:0] tag;
        logic [xlen-1:0]      target;
        logic [1:0]           ctr;
        logic                 uncond;
    } btb_entry_t;

endpackage

// File: logic/bpu_pred_if.sv
`timescale 1ns/100ps

interface bpu_pred_if;
    import frontend_pkg::*;

    // Prediction for the instruction in the fetch cycle
    logic            pred_taken;
    logic [xlen-1:0] pred_target;
    logic            is_branch;
    logic            btb_hit;

    modport producer (
        output pred_taken,
        output pred_target,
        output is_branch,
        output btb_hit
    );

    // Next pc select and buffer tagging
    modport consumer (
        input pred_taken,
        input pred_target
    );

endinterface

// File: logic/branch_update_if.sv
`timescale 1ns/100ps

interface branch_update_if;
    import frontend_pkg::*;

    // Resolved branch from the back end
    logic            upd_valid;
    logic [xlen-1:0] upd_pc;
    logic            upd_taken;
    logic [xlen-1:0] upd_target;

    // Pipeline redirect
    logic            flush;
    logic [xlen-1:0] flush_pc;

    modport update (
        input upd_valid,
        input upd_pc,
        input upd_taken,
        input upd_target
    );

    modport flush_side (
        input flush,
        input flush_pc
    );

endinterface

// File: logic/pc_reg.sv
`timescale 1ns/100ps

module pc_reg #(
    parameter logic [frontend_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          icache_valid,
    input  logic                          icache_stall,
    input  logic                          ib_full,
    bpu_pred_if.consumer                  pred,
    branch_update_if.flush_side           upd,
    output logic [frontend_pkg::xlen-1:0] fetch_pc,
    output logic                          fetch_en,
    output logic                          fetch_go
);
    import frontend_pkg::*;

    logic [xlen-1:0] next_pc;

    // Fetch is taken only when the cache answers and the buffer has room
    assign fetch_go = fetch_en && icache_valid && !icache_stall && !ib_full;

    ////////////////////
    // Next address
    ////////////////////

    always_comb begin
        next_pc = fetch_pc;
        if (upd.flush) begin
            next_pc = upd.flush_pc;
        end else if (fetch_go) begin
            if (pred.pred_taken) begin
                next_pc = pred.pred_target;
            end else begin
                next_pc = fetch_pc + xlen'(4);
            end
        end
    end

    // Enable rises on the first clock out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_en <= 1'b0;
            fetch_pc <= reset_pc;
        end else begin
            fetch_en <= 1'b1;
            fetch_pc <= next_pc;
        end
    end

endmodule

// File: logic/bpu.sv
`timescale 1ns/100ps

module bpu #(
    parameter int btb_entries = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          fetch_go,
    input  logic [frontend_pkg::xlen-1:0] fetch_pc,
    input  frontend_pkg::inst_word_u      icache_inst,
    branch_update_if.update               upd,
    bpu_pred_if.producer                  pred
);
    import frontend_pkg::*;

    localparam int idx_w = $clog2(btb_entries);

    btb_entry_t       btb [btb_entries];
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    btb_entry_t       rd_entry;
    btb_entry_t       wr_old;
    btb_entry_t       wr_new;
    logic             wr_hit;
    logic             dec_uncond;
    logic             dec_cond;

    ////////////////////
    // Lookup
    ////////////////////

    assign rd_idx   = fetch_pc[idx_w+1:2];
    assign rd_entry = btb[rd_idx];

    // Pre-decode of the fetched word
    assign dec_uncond = icache_inst.jump_view.opcode == op_b;
    assign dec_cond   = (icache_inst.cond_view.opcode == op_beq) ||
                        (icache_inst.cond_view.opcode == op_bne);

    assign pred.is_branch   = dec_uncond || dec_cond;
    assign pred.btb_hit     = rd_entry.valid && (rd_entry.tag == fetch_pc[xlen-1:2]);
    assign pred.pred_target = rd_entry.target;

    // Jumps always go, conditional ones need a counter of 2 or 3
    assign pred.pred_taken = pred.btb_hit && pred.is_branch &&
                             (dec_uncond || rd_entry.uncond || rd_entry.ctr[1]);

    ////////////////////
    // Update
    ////////////////////

    assign wr_idx = upd.upd_pc[idx_w+1:2];
    assign wr_old = btb[wr_idx];
    assign wr_hit = wr_old.valid && (wr_old.tag == upd.upd_pc[xlen-1:2]);

    always_comb begin
        wr_new.valid  = 1'b1;
        wr_new.tag    = upd.upd_pc[xlen-1:2];
        wr_new.target = (upd.upd_taken || !wr_hit) ? upd.upd_target : wr_old.target;
        wr_new.uncond = wr_hit && wr_old.uncond;
        if (!wr_hit) begin
            // Fresh entry starts weak
            wr_new.ctr = upd.upd_taken ? 2'd2 : 2'd1;
        end else if (upd.upd_taken) begin
            wr_new.ctr = (wr_old.ctr == 2'd3) ? 2'd3 : wr_old.ctr + 2'd1;
        end else begin
            wr_new.ctr = (wr_old.ctr == 2'd0) ? 2'd0 : wr_old.ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_entries; i++) begin
                btb[i] <= '0;
            end
        end else if (upd.upd_valid) begin
            btb[wr_idx] <= wr_new;
        end else if (fetch_go && pred.btb_hit && dec_uncond) begin
            // Mark the line once a jump is seen hitting it
            btb[rd_idx].uncond <= 1'b1;
        end
    end

endmodule

// File: logic/instbuffer.sv
`timescale 1ns/100ps

module instbuffer #(
    parameter int ib_depth = 8
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          fetch_go,
    input  logic [frontend_pkg::xlen-1:0] fetch_pc,
    input  logic [frontend_pkg::xlen-1:0] icache_inst,
    input  logic                          send_inst_en,
    bpu_pred_if.consumer                  pred,
    branch_update_if.flush_side           upd,
    output logic                          ib_full,
    output logic                          ib_out_valid,
    output logic [frontend_pkg::xlen-1:0] ib_out_pc,
    output logic [frontend_pkg::xlen-1:0] ib_out_inst,
    output logic                          ib_out_pred_taken,
    output logic [frontend_pkg::xlen-1:0] ib_out_pred_target
);
    import frontend_pkg::*;

    localparam int ptr_w = $clog2(ib_depth);

    logic [xlen-1:0] pc_mem     [ib_depth];
    logic [xlen-1:0] inst_mem   [ib_depth];
    logic            taken_mem  [ib_depth];
    logic [xlen-1:0] target_mem [ib_depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    assign ib_full      = count == (ptr_w + 1)'(ib_depth);
    assign ib_out_valid = count != '0;

    // A flush drops both the incoming word and the head
    assign push = fetch_go && !upd.flush;
    assign pop  = send_inst_en && ib_out_valid && !upd.flush;

    assign ib_out_pc          = pc_mem[rd_ptr];
    assign ib_out_inst        = inst_mem[rd_ptr];
    assign ib_out_pred_taken  = taken_mem[rd_ptr];
    assign ib_out_pred_target = target_mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]     <= fetch_pc;
            inst_mem[wr_ptr]   <= icache_inst;
            taken_mem[wr_ptr]  <= pred.pred_taken;
            target_mem[wr_ptr] <= pred.pred_target;
        end
    end

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (upd.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/frontend_top.sv
`timescale 1ns/100ps

module frontend_top #(
    parameter logic [frontend_pkg::xlen-1:0] reset_pc    = '0,
    parameter int                            btb_entries = 16,
    parameter int                            ib_depth    = 8
) (
    input  logic                          clk,
    input  logic                          arst_n,
    // Cache reply
    input  logic [frontend_pkg::xlen-1:0] icache_inst,
    input  logic                          icache_valid,
    input  logic                          icache_stall,
    // Back end
    input  logic                          send_inst_en,
    input  logic                          upd_valid,
    input  logic [frontend_pkg::xlen-1:0] upd_pc,
    input  logic                          upd_taken,
    input  logic [frontend_pkg::xlen-1:0] upd_target,
    input  logic                          flush,
    input  logic [frontend_pkg::xlen-1:0] flush_pc,
    // Fetch request
    output logic [frontend_pkg::xlen-1:0] fetch_pc,
    output logic                          fetch_en,
    // Buffer head
    output logic                          ib_full,
    output logic                          ib_out_valid,
    output logic [frontend_pkg::xlen-1:0] ib_out_pc,
    output logic [frontend_pkg::xlen-1:0] ib_out_inst,
    output logic                          ib_out_pred_taken,
    output logic [frontend_pkg::xlen-1:0] ib_out_pred_target
);

    logic fetch_go;

    bpu_pred_if      pred_bus ();
    branch_update_if upd_bus ();

    // Back-end strobes onto the update bus
    assign upd_bus.upd_valid  = upd_valid;
    assign upd_bus.upd_pc     = upd_pc;
    assign upd_bus.upd_taken  = upd_taken;
    assign upd_bus.upd_target = upd_target;
    assign upd_bus.flush      = flush;
    assign upd_bus.flush_pc   = flush_pc;

    pc_reg #(
        .reset_pc(reset_pc)
    ) u_pc_reg (
        .clk,
        .arst_n,
        .icache_valid,
        .icache_stall,
        .ib_full,
        .pred(pred_bus.consumer),
        .upd(upd_bus.flush_side),
        .fetch_pc,
        .fetch_en,
        .fetch_go
    );

    bpu #(
        .btb_entries(btb_entries)
    ) u_bpu (
        .clk,
        .arst_n,
        .fetch_go,
        .fetch_pc,
        .icache_inst,
        .upd(upd_bus.update),
        .pred(pred_bus.producer)
    );

    instbuffer #(
        .ib_depth(ib_depth)
    ) u_instbuffer (
        .clk,
        .arst_n,
        .fetch_go,
        .fetch_pc,
        .icache_inst,
        .send_inst_en,
        .pred(pred_bus.consumer),
        .upd(upd_bus.flush_side),
        .ib_full,
        .ib_out_valid,
        .ib_out_pc,
        .ib_out_inst,
        .ib_out_pred_taken,
        .ib_out_pred_target
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real period = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2.0);
        clk = ~clk;
    end

endmodule

// File: test/frontend_properties.sv
`timescale 1ns/100ps

module frontend_properties (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          icache_stall,
    input logic                          flush,
    input logic                          ib_full,
    input logic                          ib_out_valid,
    input logic [frontend_pkg::xlen-1:0] fetch_pc
);

    // Buffer flags are cleared while reset is held
    reset_empty: assert property (@(posedge clk) !arst_n |-> !ib_full && !ib_out_valid)
        else $error("buffer flags set during reset");

    // A stalled cache keeps the fetch address
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        icache_stall && !flush |=> fetch_pc == $past(fetch_pc))
        else $error("fetch_pc moved during a cache stall");

    flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !ib_out_valid)
        else $error("buffer not empty the cycle after a flush");

endmodule

bind frontend_top frontend_properties u_frontend_properties (
    .clk(clk),
    .arst_n(arst_n),
    .icache_stall(icache_stall),
    .flush(flush),
    .ib_full(ib_full),
    .ib_out_valid(ib_out_valid),
    .fetch_pc(fetch_pc)
);

// File: test/frontend_tb.sv
`timescale 1ns/100ps

module frontend_tb;
    import frontend_pkg::*;

    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam int          btb_n    = 16;
    localparam int          ib_n     = 8;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        tk;
        logic [31:0] tgt;
    } entry_t;

    logic        clk, arst_n, icache_valid, icache_stall, send_inst_en;
    logic        upd_valid, upd_taken, flush, fetch_en, ib_full, ib_out_valid, ib_out_pred_taken;
    logic [31:0] icache_inst, upd_pc, upd_target, flush_pc, fetch_pc;
    logic [31:0] ib_out_pc, ib_out_inst, ib_out_pred_target;

    // Reference BTB and buffer queue
    logic        m_valid [btb_n] = '{default: '0};
    logic [29:0] m_tag [btb_n] = '{default: '0};
    logic [31:0] m_tgt [btb_n] = '{default: '0};
    logic [1:0]  m_ctr [btb_n] = '{default: '0};
    entry_t      q [$];
    entry_t      prev;
    logic [31:0] m_pc = reset_pc;
    logic        m_en = 1'b0;
    logic        rand_mode = 1'b0;
    logic        fetch_on = 1'b1;
    logic        pop_on = 1'b1;
    logic        chain_ok = 1'b0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_taken = 0;
    int          n_nt_beq = 0;

    tb_clock_gen #(.period(4.0)) u_clock (.clk(clk));

    frontend_top #(
        .reset_pc(reset_pc),
        .btb_entries(btb_n),
        .ib_depth(ib_n)
    ) i_frontend_top (.*);

    ////////////////////
    // Memory and predictor models
    ////////////////////

    // Two branch sites, a loop 0x40..0x88 once both are trained
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr == 32'h44) begin
            return {op_beq, 5'd1, 5'd2, 16'h000e};
        end else if (addr == 32'h88) begin
            return {op_b, 26'h3ff_ffee};
        end
        return {6'h23, addr[27:2] ^ addr[31:6]};
    endfunction

    // Cache answers in the same cycle
    assign icache_inst = mem_word(fetch_pc);

    function automatic entry_t predict(input logic [31:0] pc);
        entry_t     e;
        logic [5:0] op;
        e.pc   = pc;
        e.inst = mem_word(pc);
        e.tgt  = m_tgt[pc[5:2]];
        op     = e.inst[31:26];
        e.tk   = m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[31:2]) &&
                 (op == op_b || ((op == op_beq || op == op_bne) && m_ctr[pc[5:2]] >= 2'd2));
        return e;
    endfunction

    function automatic void model_update(input logic [31:0] pc, input logic tk,
                                         input logic [31:0] tgt);
        logic hit;
        hit = m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[31:2]);
        if (!hit) begin
            m_ctr[pc[5:2]] = tk ? 2'd2 : 2'd1;
        end else if (tk && m_ctr[pc[5:2]] != 2'd3) begin
            m_ctr[pc[5:2]] = m_ctr[pc[5:2]] + 2'd1;
        end else if (!tk && m_ctr[pc[5:2]] != 2'd0) begin
            m_ctr[pc[5:2]] = m_ctr[pc[5:2]] - 2'd1;
        end
        if (tk || !hit) begin
            m_tgt[pc[5:2]] = tgt;
        end
        m_valid[pc[5:2]] = 1'b1;
        m_tag[pc[5:2]]   = pc[31:2];
    endfunction

    ////////////////////
    // Checking
    ////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic timed_out(input string what);
        n_errors++;
        $display("Timeout: %s did not happen in time", what);
    endtask

    // Values seen here are the ones the DUT samples at this edge
    task automatic observe();
        entry_t e;
        logic   acc;
        check("fetch_en", 32'(m_en), 32'(fetch_en));
        check("ib_out_valid", 32'(q.size() != 0), 32'(ib_out_valid));
        check("ib_full", 32'(q.size() == ib_n), 32'(ib_full));
        acc = m_en && icache_valid && !icache_stall && (q.size() < ib_n);
        if (flush) begin
            q.delete();
            m_pc     = flush_pc;
            chain_ok = 1'b0;
        end else begin
            if (send_inst_en && q.size() != 0) begin
                e = q.pop_front();
                check("pop_pc", e.pc, ib_out_pc);
                check("pop_inst", e.inst, ib_out_inst);
                check("pop_taken", 32'(e.tk), 32'(ib_out_pred_taken));
                if (e.tk) begin
                    check("pop_target", e.tgt, ib_out_pred_target);
                    n_taken++;
                end
                if (chain_ok) begin
                    check("pop_follows", prev.tk ? prev.tgt : prev.pc + 32'd4, ib_out_pc);
                end
                if (e.pc == 32'h44 && !e.tk) begin
                    n_nt_beq++;
                end
                prev     = e;
                chain_ok = 1'b1;
            end
            if (acc) begin
                check("fetch_pc", m_pc, fetch_pc);
                e = predict(m_pc);
                q.push_back(e);
                m_pc = e.tk ? e.tgt : m_pc + 32'd4;
            end
        end
        if (upd_valid) begin
            model_update(upd_pc, upd_taken, upd_target);
        end
        m_en = 1'b1;
    endtask

    task automatic step(input logic fl, input logic [31:0] fpc, input logic uv,
                        input logic [31:0] upc, input logic ut);
        @(posedge clk);
        observe();
        flush      <= fl;
        flush_pc   <= fpc;
        upd_valid  <= uv;
        upd_pc     <= upc;
        upd_taken  <= ut;
        upd_target <= (upc == 32'h44) ? 32'h80 : 32'h40;
        if (rand_mode) begin
            send_inst_en <= ($urandom % 4) != 0;
            icache_stall <= ($urandom % 4) == 0;
            icache_valid <= ($urandom % 8) != 0;
        end else begin
            send_inst_en <= pop_on;
            icache_stall <= 1'b0;
            icache_valid <= fetch_on;
        end
    endtask

    task automatic idle();
        step(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        int t;
        int r;
        int base;
        void'($urandom(32'h4686f438));
        arst_n       <= 1'b0;
        icache_valid <= 1'b0;
        icache_stall <= 1'b0;
        send_inst_en <= 1'b0;
        upd_valid    <= 1'b0;
        upd_taken    <= 1'b0;
        upd_pc       <= '0;
        upd_target   <= '0;
        flush        <= 1'b0;
        flush_pc     <= '0;
        repeat (5) @(posedge clk);
        arst_n       <= 1'b1;
        icache_valid <= 1'b1;
        send_inst_en <= 1'b1;

        // Straight-line fetch from reset_pc
        repeat (60) idle();

        // Back end holds off until the buffer is full and fetch stalls
        pop_on = 1'b0;
        repeat (ib_n + 4) idle();
        pop_on = 1'b1;

        // Random back-pressure with flushes and updates
        rand_mode = 1'b1;
        repeat (400) begin
            r = int'($urandom % 32);
            if (r == 0) begin
                step(1'b1, $urandom & 32'hffff_fffc, 1'b0, 32'h0, 1'b0);
            end else if (r == 1) begin
                step(1'b1, 32'h40, 1'b0, 32'h0, 1'b0);
            end else if (r < 4) begin
                step(1'b0, 32'h0, 1'b1, (r == 2) ? 32'h44 : 32'h88, ($urandom % 2) != 0);
            end else begin
                idle();
            end
        end

        // Train both branches taken, then run the loop
        rand_mode = 1'b0;
        step(1'b0, 32'h0, 1'b1, 32'h44, 1'b1);
        step(1'b0, 32'h0, 1'b1, 32'h44, 1'b1);
        step(1'b0, 32'h0, 1'b1, 32'h88, 1'b1);
        step(1'b1, 32'h40, 1'b0, 32'h0, 1'b0);
        base = n_taken;
        t = 0;
        while (n_taken < base + 6 && t < 200) begin
            idle();
            t++;
        end
        if (n_taken < base + 6) begin
            timed_out("taken predictions after training");
        end

        // Decay both counters below 2
        // The jump stays taken on a hit
        repeat (3) step(1'b0, 32'h0, 1'b1, 32'h44, 1'b0);
        repeat (3) step(1'b0, 32'h0, 1'b1, 32'h88, 1'b0);
        step(1'b1, 32'h40, 1'b0, 32'h0, 1'b0);
        base = n_nt_beq;
        t = 0;
        while (n_nt_beq < base + 2 && t < 200) begin
            idle();
            t++;
        end
        if (n_nt_beq < base + 2) begin
            timed_out("not-taken conditional branch after decay");
        end

        // Drain the buffer
        fetch_on = 1'b0;
        t = 0;
        while ((q.size() != 0 || ib_out_valid) && t < 50) begin
            idle();
            t++;
        end
        if (q.size() != 0 || ib_out_valid) begin
            timed_out("buffer drain");
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/frontend_pkg.sv
logic/bpu_pred_if.sv
logic/branch_update_if.sv
logic/pc_reg.sv
logic/bpu.sv
logic/instbuffer.sv
logic/frontend_top.sv
test/tb_clock_gen.sv
test/frontend_properties.sv
test/frontend_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = frontend_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
